// File: common/mext_isa_pkg.sv
// RISC-V M-extension ISA definitions: word width, operation codes and funct3 encodings
`default_nettype none

package mext_isa_pkg;

    // Machine word width
    localparam int unsigned XLEN = 32;

    // Decoded M operation, zero means nothing held
    typedef enum logic [3:0] {
        M_NONE   = 4'd0,
        M_MUL    = 4'd1,
        M_MULH   = 4'd2,
        M_MULHSU = 4'd3,
        M_MULHU  = 4'd4,
        M_DIV    = 4'd5,
        M_DIVU   = 4'd6,
        M_REM    = 4'd7,
        M_REMU   = 4'd8
    } m_op_e;

    // funct3 field of OP opcode with funct7 = 0000001
    localparam logic [2:0] F3_MUL    = 3'd0;
    localparam logic [2:0] F3_MULH   = 3'd1;
    localparam logic [2:0] F3_MULHSU = 3'd2;
    localparam logic [2:0] F3_MULHU  = 3'd3;
    localparam logic [2:0] F3_DIV    = 3'd4;
    localparam logic [2:0] F3_DIVU   = 3'd5;
    localparam logic [2:0] F3_REM    = 3'd6;
    localparam logic [2:0] F3_REMU   = 3'd7;

endpackage

`default_nettype wire

// File: common/mext_pipe_pkg.sv
// Pipeline control definitions for the M-extension forward/stall logic
`default_nettype none

package mext_pipe_pkg;

    // Architectural register index width
    localparam int unsigned REG_IDX_W = 5;

    // Forward/stall controller states
    typedef enum logic [1:0] {
        FS_IDLE  = 2'd0,
        FS_EXEC  = 2'd1,
        FS_DRAIN = 2'd2
    } fwd_state_e;

endpackage

`default_nettype wire

// File: rtl/m_issue.sv
// Issue register that decodes funct3 into an M operation and holds it until flushed
`default_nettype none

module m_issue (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             valid_i,
    input  wire logic [2:0]                       funct3_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0]    operand_a_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0]    operand_b_i,
    input  wire logic [mext_pipe_pkg::REG_IDX_W-1:0] rd_i,
    input  wire logic                             flush_i,
    input  wire logic                             drain_i,
    output mext_isa_pkg::m_op_e                   op_o,
    output logic [mext_isa_pkg::XLEN-1:0]         operand_1_o,
    output logic [mext_isa_pkg::XLEN-1:0]         operand_2_o,
    output logic [mext_pipe_pkg::REG_IDX_W-1:0]   rd_o,
    output logic                                  held_o
);

    import mext_isa_pkg::*;

    logic  capture;
    m_op_e op_dec;

    always_comb begin
        case (funct3_i)
            F3_MUL:    op_dec = M_MUL;
            F3_MULH:   op_dec = M_MULH;
            F3_MULHSU: op_dec = M_MULHSU;
            F3_MULHU:  op_dec = M_MULHU;
            F3_DIV:    op_dec = M_DIV;
            F3_DIVU:   op_dec = M_DIVU;
            F3_REM:    op_dec = M_REM;
            default:   op_dec = M_REMU;
        endcase
    end

    assign held_o  = (op_o != M_NONE);
    // No capture while busy or while the ack pipe drains
    assign capture = valid_i && !held_o && !drain_i;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            op_o <= M_NONE;
        end else if (capture) begin
            op_o <= op_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            operand_1_o <= operand_a_i;
            operand_2_o <= operand_b_i;
            rd_o        <= rd_i;
        end
    end

endmodule

`default_nettype wire

// File: muldiv/muldiv.sv
// Single-step multiply/divide unit with registered result, request and delayed acknowledge
`default_nettype none

module muldiv (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire mext_isa_pkg::m_op_e           op_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0] operand_1_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0] operand_2_i,
    input  wire logic                          stall_i,
    input  wire logic                          flush_i,
    output logic                               mul_req_o,
    output logic                               mul_ack_o,
    output logic [mext_isa_pkg::XLEN-1:0]      result_o
);

    import mext_isa_pkg::*;

    logic [2*XLEN-1:0] mult_uu;
    logic [2*XLEN-1:0] mult_ss;
    logic [2*XLEN-1:0] mult_su;
    logic [XLEN-1:0]   div_s;
    logic [XLEN-1:0]   div_u;
    logic [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]   rem_u;
    logic              op2_zero;
    logic              div_ovf;
    logic              req_next;
    logic [XLEN-1:0]   result_next;
    logic              ack_q;

    assign op2_zero = (operand_2_i == '0);
    // Most negative dividend over -1
    assign div_ovf  = (operand_1_i == {1'b1, {(XLEN-1){1'b0}}}) && (operand_2_i == '1);
    assign req_next = (op_i != M_NONE);

    always_comb begin
        // Full 2*XLEN products from explicitly extended operands
        mult_uu = {{XLEN{1'b0}}, operand_1_i} * {{XLEN{1'b0}}, operand_2_i};
        mult_ss = {{XLEN{operand_1_i[XLEN-1]}}, operand_1_i} *
                  {{XLEN{operand_2_i[XLEN-1]}}, operand_2_i};
        mult_su = {{XLEN{operand_1_i[XLEN-1]}}, operand_1_i} *
                  {{XLEN{1'b0}}, operand_2_i};

        if (op2_zero) begin
            div_s = '1;
            div_u = '1;
            rem_s = operand_1_i;
            rem_u = operand_1_i;
        end else begin
            div_u = operand_1_i / operand_2_i;
            rem_u = operand_1_i % operand_2_i;
            if (div_ovf) begin
                div_s = operand_1_i;
                rem_s = '0;
            end else begin
                div_s = $signed(operand_1_i) / $signed(operand_2_i);
                rem_s = $signed(operand_1_i) % $signed(operand_2_i);
            end
        end
    end

    always_comb begin
        case (op_i)
            M_MUL:    result_next = mult_ss[XLEN-1:0];
            M_MULH:   result_next = mult_ss[2*XLEN-1:XLEN];
            M_MULHSU: result_next = mult_su[2*XLEN-1:XLEN];
            M_MULHU:  result_next = mult_uu[2*XLEN-1:XLEN];
            M_DIV:    result_next = div_s;
            M_DIVU:   result_next = div_u;
            M_REM:    result_next = rem_s;
            M_REMU:   result_next = rem_u;
            default:  result_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            mul_req_o <= 1'b0;
            result_o  <= '0;
        end else if (!stall_i) begin
            mul_req_o <= req_next;
            result_o  <= result_next;
        end
    end

    // Ack trails the request by two flops, flush does not touch it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q     <= 1'b0;
            mul_ack_o <= 1'b0;
        end else begin
            ack_q     <= req_next;
            mul_ack_o <= ack_q;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mext_fwd_stall.sv
// Forward/stall controller deriving stall, completion, flush and busy for the M unit
`default_nettype none

module mext_fwd_stall (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic mul_req_i,
    input  wire logic mul_ack_i,
    input  wire logic held_i,
    input  wire logic kill_i,
    output logic      stall_o,
    output logic      complete_o,
    output logic      flush_o,
    output logic      drain_o,
    output logic      busy_o
);

    import mext_pipe_pkg::*;

    fwd_state_e state_q;
    fwd_state_e state_d;
    logic       exec_phase;

    // Executing, or entering execute on this request
    assign exec_phase = (state_q == FS_EXEC) || ((state_q == FS_IDLE) && mul_req_i);

    assign stall_o    = exec_phase && mul_req_i && !mul_ack_i;
    // Kill wins over a completion in the same cycle
    assign complete_o = (state_q == FS_EXEC) && mul_req_i && mul_ack_i && !kill_i;
    assign flush_o    = complete_o || kill_i;
    assign drain_o    = (state_q == FS_DRAIN);
    assign busy_o     = held_i || drain_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FS_IDLE: begin
                if (kill_i && held_i) begin
                    state_d = FS_DRAIN;
                end else if (mul_req_i) begin
                    state_d = FS_EXEC;
                end
            end
            FS_EXEC: begin
                if (kill_i) begin
                    state_d = FS_DRAIN;
                end else if (complete_o || !mul_req_i) begin
                    state_d = FS_IDLE;
                end
            end
            FS_DRAIN: begin
                // Stale ack must be gone before the next capture
                if (!mul_ack_i) begin
                    state_d = FS_IDLE;
                end
            end
            default: state_d = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= FS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mext_writeback.sv
// Writeback register that retires one M result per completion and drops writes to x0
`default_nettype none

module mext_writeback (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               complete_i,
    input  wire logic [mext_pipe_pkg::REG_IDX_W-1:0] rd_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0]      result_i,
    output logic                                    we_o,
    output logic [mext_pipe_pkg::REG_IDX_W-1:0]     rd_o,
    output logic [mext_isa_pkg::XLEN-1:0]           result_o
);

    logic write_en;

    // x0 is hardwired, so nothing retires for it
    assign write_en = complete_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_o     <= 1'b0;
            rd_o     <= '0;
            result_o <= '0;
        end else begin
            we_o <= write_en;
            if (write_en) begin
                rd_o     <= rd_i;
                result_o <= result_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mext_top.sv
// M-extension block top level joining issue, multiply/divide, forward/stall and writeback
`default_nettype none

module mext_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               valid_i,
    input  wire logic [2:0]                         funct3_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0]      operand_a_i,
    input  wire logic [mext_isa_pkg::XLEN-1:0]      operand_b_i,
    input  wire logic [mext_pipe_pkg::REG_IDX_W-1:0] rd_i,
    input  wire logic                               kill_i,
    output logic                                    busy_o,
    output logic                                    we_o,
    output logic [mext_pipe_pkg::REG_IDX_W-1:0]     rd_o,
    output logic [mext_isa_pkg::XLEN-1:0]           result_o
);

    import mext_isa_pkg::*;
    import mext_pipe_pkg::*;

    m_op_e                op;
    logic [XLEN-1:0]      operand_1;
    logic [XLEN-1:0]      operand_2;
    logic [REG_IDX_W-1:0] rd;
    logic                 held;
    logic                 mul_req;
    logic                 mul_ack;
    logic [XLEN-1:0]      mul_result;
    logic                 stall;
    logic                 flush;
    logic                 complete;
    logic                 drain;

    m_issue m_issue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .funct3_i    (funct3_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .rd_i        (rd_i),
        .flush_i     (flush),
        .drain_i     (drain),
        .op_o        (op),
        .operand_1_o (operand_1),
        .operand_2_o (operand_2),
        .rd_o        (rd),
        .held_o      (held)
    );

    muldiv muldiv_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_i        (op),
        .operand_1_i (operand_1),
        .operand_2_i (operand_2),
        .stall_i     (stall),
        .flush_i     (flush),
        .mul_req_o   (mul_req),
        .mul_ack_o   (mul_ack),
        .result_o    (mul_result)
    );

    mext_fwd_stall mext_fwd_stall_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_req_i  (mul_req),
        .mul_ack_i  (mul_ack),
        .held_i     (held),
        .kill_i     (kill_i),
        .stall_o    (stall),
        .complete_o (complete),
        .flush_o    (flush),
        .drain_o    (drain),
        .busy_o     (busy_o)
    );

    mext_writeback mext_writeback_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .complete_i (complete),
        .rd_i       (rd),
        .result_i   (mul_result),
        .we_o       (we_o),
        .rd_o       (rd_o),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire

// File: bench/mext_checker.sv
// Concurrent assertions on the M-extension write strobe, busy level and kill
`default_nettype none

module mext_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic kill_i,
    input wire logic busy_i,
    input wire logic we_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    we_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) we_i |=> !we_i)
        else begin
            fail_count++;
            $error("we_o stayed high for two cycles");
        end

    we_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(we_i && busy_i))
        else begin
            fail_count++;
            $error("we_o and busy_o high together");
        end

    // Nothing retires in the three cycles after a kill
    no_we_after_kill: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(kill_i, 1) || $past(kill_i, 2) || $past(kill_i, 3)) |-> !we_i)
        else begin
            fail_count++;
            $error("we_o followed kill_i");
        end

    we_low_after_reset: assert property (@(posedge clk) !rst_n |=> !we_i)
        else begin
            fail_count++;
            $error("we_o high in the cycle after reset");
        end

endmodule

bind mext_top mext_checker mext_checker_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .kill_i (kill_i),
    .busy_i (busy_o),
    .we_i   (we_o)
);

`default_nettype wire

// File: bench/mext_tb.sv
// Testbench for the M-extension block running a table of directed and random instructions
`default_nettype none

module mext_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mext_isa_pkg::*;
    import mext_pipe_pkg::*;

    localparam int WAIT_LIMIT = 40;

    // kill_at is the cycle after capture that carries kill_i, zero for none
    typedef struct packed {
        logic [2:0]           funct3;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
        logic [REG_IDX_W-1:0] rd;
        logic [1:0]           kill_at;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 valid_i;
    logic [2:0]           funct3_i;
    logic [XLEN-1:0]      operand_a_i;
    logic [XLEN-1:0]      operand_b_i;
    logic [REG_IDX_W-1:0] rd_i;
    logic                 kill_i;
    logic                 busy_o;
    logic                 we_o;
    logic [REG_IDX_W-1:0] rd_o;
    logic [XLEN-1:0]      result_o;

    row_t                 rows[$];
    int                   errors;
    int                   tests;
    bit                   timed_out;
    logic [REG_IDX_W-1:0] last_rd;
    logic [XLEN-1:0]      last_result;

    mext_top mext_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .funct3_i    (funct3_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .rd_i        (rd_i),
        .kill_i      (kill_i),
        .busy_o      (busy_o),
        .we_o        (we_o),
        .rd_o        (rd_o),
        .result_o    (result_o)
    );

    always #2 clk = ~clk;

    // RISC-V M rules on 64-bit intermediates
    function automatic logic [XLEN-1:0] expected_result(input logic [2:0] f3,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        longint          ps;
        longint unsigned pu;
        logic [XLEN-1:0] r;
        logic            ovf;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ua  = {32'd0, a};
        ub  = {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        ps  = sa * sb;
        case (f3)
            F3_MUL:    r = ps[31:0];
            F3_MULH:   r = ps[63:32];
            F3_MULHSU: begin
                ps = sa * longint'(ub);
                r  = ps[63:32];
            end
            F3_MULHU:  begin
                pu = ua * ub;
                r  = pu[63:32];
            end
            F3_DIV:    begin
                ps = (sb == 0) ? -64'sd1 : (ovf ? sa : sa / sb);
                r  = ps[31:0];
            end
            F3_DIVU:   begin
                pu = (ub == 0) ? 64'hffff_ffff : ua / ub;
                r  = pu[31:0];
            end
            F3_REM:    begin
                ps = (sb == 0) ? sa : (ovf ? 64'sd0 : sa % sb);
                r  = ps[31:0];
            end
            default:   begin
                pu = (ub == 0) ? ua : ua % ub;
                r  = pu[31:0];
            end
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_IDX_W-1:0] got,
                            input logic [REG_IDX_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic [2:0] f3, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [REG_IDX_W-1:0] rd,
                           input logic [1:0] kill_at);
        rows.push_back('{funct3: f3, a: a, b: b, rd: rd, kill_at: kill_at});
    endtask

    task automatic fill_table();
        logic [XLEN-1:0] b;
        logic [1:0]      k;
        add_row(F3_MUL,    32'd7,          32'hffff_fffd, 5'd1,  2'd0);
        add_row(F3_MUL,    32'h8000_0000,  32'hffff_ffff, 5'd2,  2'd0);
        add_row(F3_MULH,   32'h8000_0000,  32'h8000_0000, 5'd3,  2'd0);
        add_row(F3_MULH,   32'hffff_ffff,  32'hffff_ffff, 5'd4,  2'd0);
        add_row(F3_MULHSU, 32'hffff_ffff,  32'hffff_ffff, 5'd5,  2'd0);
        add_row(F3_MULHSU, 32'h8000_0000,  32'd2,         5'd6,  2'd0);
        add_row(F3_MULHU,  32'hffff_ffff,  32'hffff_ffff, 5'd7,  2'd0);
        add_row(F3_MULHU,  32'h1234_5678,  32'h9abc_def0, 5'd8,  2'd0);
        add_row(F3_DIV,    32'hffff_ffec,  32'd3,         5'd9,  2'd0);
        add_row(F3_DIV,    32'd1234,       32'd0,         5'd10, 2'd0);
        add_row(F3_DIV,    32'h8000_0000,  32'hffff_ffff, 5'd11, 2'd0);
        add_row(F3_DIVU,   32'd100,        32'd7,         5'd12, 2'd0);
        add_row(F3_DIVU,   32'hdead_beef,  32'd0,         5'd13, 2'd0);
        add_row(F3_REM,    32'hffff_ffec,  32'd3,         5'd14, 2'd0);
        add_row(F3_REM,    32'hffff_fff0,  32'd0,         5'd15, 2'd0);
        add_row(F3_REM,    32'h8000_0000,  32'hffff_ffff, 5'd16, 2'd0);
        add_row(F3_REMU,   32'd100,        32'd7,         5'd17, 2'd0);
        add_row(F3_REMU,   32'hcafe_f00d,  32'd0,         5'd18, 2'd0);
        // Killed in each cycle of flight, each followed by a live row
        add_row(F3_MUL,    32'd5,          32'd6,         5'd19, 2'd1);
        add_row(F3_DIVU,   32'd81,         32'd9,         5'd20, 2'd0);
        add_row(F3_MULHU,  32'hffff_0000,  32'h0001_0000, 5'd21, 2'd2);
        add_row(F3_REM,    32'd77,         32'd10,        5'd22, 2'd0);
        add_row(F3_DIV,    32'd99,         32'd4,         5'd23, 2'd3);
        add_row(F3_MULH,   32'h7fff_ffff,  32'h7fff_ffff, 5'd24, 2'd0);
        add_row(F3_MUL,    32'd3,          32'd3,         5'd0,  2'd0);
        add_row(F3_REMU,   32'd50,         32'd8,         5'd31, 2'd0);
        for (int i = 0; i < 32; i++) begin
            b = $urandom();
            if ($urandom_range(7) == 0) begin
                b = '0;
            end
            k = ($urandom_range(7) == 0) ? 2'($urandom_range(3, 1)) : 2'd0;
            add_row(3'($urandom_range(7)), $urandom(), b, 5'($urandom_range(31)), k);
        end
    endtask

    task automatic wait_idle(input int test);
        int n;
        n = 0;
        while (busy_o !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: busy_o never fell before test %0d", test);
        end
    endtask

    task automatic run_row(input int test, input row_t r);
        int              lat;
        int              err_before;
        bit              want_we;
        bit              done;
        logic [XLEN-1:0] exp;
        err_before = errors;
        want_we    = (r.kill_at == 2'd0) && (r.rd != '0);
        exp        = expected_result(r.funct3, r.a, r.b);
        wait_idle(test);
        if (timed_out) begin
            return;
        end
        valid_i     = 1'b1;
        funct3_i    = r.funct3;
        operand_a_i = r.a;
        operand_b_i = r.b;
        rd_i        = r.rd;
        lat         = -1;
        done        = 1'b0;
        while (!done && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
            kill_i = (r.kill_at != 2'd0) && (lat == int'(r.kill_at) - 1);
            if (want_we && we_o === 1'b1) begin
                done = 1'b1;
            end else if (!want_we && busy_o === 1'b0) begin
                done = 1'b1;
            end else if (want_we) begin
                check_bit("busy_o", busy_o, 1'b1);
            end
            // Offer a different instruction while busy
            if (busy_o === 1'b1) begin
                funct3_i    = r.funct3 ^ 3'd1;
                operand_a_i = ~r.a;
                operand_b_i = ~r.b;
                rd_i        = r.rd ^ 5'h1f;
            end else begin
                valid_i = 1'b0;
            end
        end
        valid_i = 1'b0;
        kill_i  = 1'b0;
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: test %0d never retired or went idle", test);
            return;
        end
        if (want_we) begin
            check_count("latency", lat, 3);
            check_bit("busy_o", busy_o, 1'b0);
            check_rd("rd_o", rd_o, r.rd);
            check_word("result_o", result_o, exp);
            last_rd     = r.rd;
            last_result = exp;
        end else begin
            check_bit("we_o", we_o, 1'b0);
            @(negedge clk);
            check_bit("we_o", we_o, 1'b0);
            check_rd("rd_o", rd_o, last_rd);
            check_word("result_o", result_o, last_result);
        end
        tests++;
        $display("test %0d f3=%0d a=%h b=%h rd=%0d kill=%0d: %s", test, r.funct3, r.a, r.b,
                 r.rd, r.kill_at, (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        int total;
        errors      = 0;
        tests       = 0;
        timed_out   = 1'b0;
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        funct3_i    = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        rd_i        = '0;
        kill_i      = 1'b0;
        last_rd     = '0;
        last_result = '0;
        void'($urandom(32'h9306_f067));
        fill_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("we_o", we_o, 1'b0);
        check_word("result_o", result_o, '0);
        check_rd("rd_o", rd_o, '0);
        tests++;
        $display("test 0 reset values: %s", (errors == 0) ? "pass" : "fail");
        foreach (rows[i]) begin
            if (!timed_out) begin
                run_row(i + 1, rows[i]);
            end
        end
        repeat (4) @(negedge clk);
        total = errors + int'(mext_top_inst.mext_checker_inst.fail_count);
        $display("tests %0d, check mismatches %0d, assertion failures %0d, timeout %0d",
                 tests, errors, mext_top_inst.mext_checker_inst.fail_count, timed_out);
        if (total == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/mext_isa_pkg.sv
common/mext_pipe_pkg.sv
rtl/m_issue.sv
muldiv/muldiv.sv
rtl/mext_fwd_stall.sv
rtl/mext_writeback.sv
rtl/mext_top.sv
bench/mext_checker.sv
bench/mext_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mext_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
